/* include/dcache_defines.svh */
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// byte address and pipeline word
`define ADDR_WIDTH 32
`define WORD_WIDTH 32

// one block is two words
`define BLOCK_WIDTH 64

// sets per way
`define N_SETS 64

// derived address split
`define OFFSET_BITS $clog2(`BLOCK_WIDTH / 8)
`define INDEX_BITS $clog2(`N_SETS)
`define TAG_BITS (`ADDR_WIDTH - `OFFSET_BITS - `INDEX_BITS)

// byte lanes in one block
`define BLOCK_BYTES (`BLOCK_WIDTH / 8)

// lfsr must never start at zero
`define LFSR_SEED 8'hb5

`endif

/* hdl/dcache_pkg.sv */
`include "dcache_defines.svh"

package dcache_pkg;

    typedef logic [`ADDR_WIDTH-1:0] addr_t;
    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [`BLOCK_WIDTH-1:0] block_t;

    typedef logic [`OFFSET_BITS-1:0] offset_t;
    typedef logic [`INDEX_BITS-1:0] index_t;
    typedef logic [`TAG_BITS-1:0] tag_t;
    typedef logic [`TAG_BITS+`INDEX_BITS-1:0] block_addr_t; // {tag, index}

    typedef enum logic {READ, WRITE} req_type_t;
    typedef enum logic [1:0] {BYTE, HALFWORD, WORD} req_width_t;

    typedef struct packed {
        req_type_t req_type;
        req_width_t width;
        addr_t addr;
        word_t wr_data; // stores only
    } cache_req_t;

    typedef struct packed {
        req_type_t req_type;
        block_addr_t block_addr;
        block_t block_data; // store data replicated across the block
        req_width_t width;
        addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_way_t;

    typedef struct packed {
        tag_way_t way1;
        tag_way_t way0;
    } tag_set_t;

    typedef struct packed {
        block_t way1;
        block_t way0;
    } data_set_t;

    // tag compare outcome whose hit is sel_way0 | sel_way1
    typedef struct packed {
        logic valid;
        logic sel_way0;
        logic sel_way1;
        logic [1:0] way_valid; // {way1, way0} valid bits of the set
        cache_req_t req;
    } lookup_t;

endpackage

/* hdl/sram_1rw.sv */
`timescale 1ns/100ps

module sram_1rw #(
    parameter type payload_t = logic [31:0],
    parameter int DEPTH = 64,
    parameter int LANES = 4
) (
    input logic clk,
    input logic init,
    input logic en,
    input logic we,
    input logic [LANES-1:0] wmask,
    input logic [$clog2(DEPTH)-1:0] addr,
    input payload_t din,
    output payload_t dout
);

    localparam int W = $bits(payload_t);
    localparam int LANE_W = W / LANES;

    logic [W-1:0] mem [DEPTH];
    logic [W-1:0] din_bits;
    logic [W-1:0] rd_q;

    assign din_bits = din;
    assign dout = rd_q;

    // a write cycle on the single port leaves the read register alone
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0; // all valid bits read back as zero
            end
            rd_q <= '0;
        end else if (en) begin
            if (we) begin
                for (int l = 0; l < LANES; l++) begin
                    if (wmask[l]) begin
                        mem[addr][l*LANE_W +: LANE_W] <= din_bits[l*LANE_W +: LANE_W];
                    end
                end
            end else begin
                rd_q <= mem[addr];
            end
        end
    end

endmodule

/* hdl/way_lfsr.sv */
`timescale 1ns/100ps

`include "dcache_defines.svh"

module way_lfsr (
    input logic clk,
    input logic init,
    output logic way
);

    logic [7:0] state;
    logic feedback;

    // taps 8,6,5,4 give the full 255-state sequence
    assign feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
    assign way = state[0];

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            state <= `LFSR_SEED;
        end else begin
            state <= {state[6:0], feedback}; // free running
        end
    end

endmodule

/* hdl/tag_decode.sv */
`timescale 1ns/100ps

`include "dcache_defines.svh"

module tag_decode
    import dcache_pkg::*;
(
    input logic clk,
    input logic init,
    input logic req_valid,
    input cache_req_t req,
    input tag_set_t tag_dout,
    output logic tag_en,
    output index_t tag_index,
    output index_t data_index,
    output lookup_t lookup
);

    index_t req_index;

    logic valid_q;
    cache_req_t req_q;
    tag_t tag_q;

    logic sel_way0;
    logic sel_way1;

    assign req_index = req.addr[`OFFSET_BITS +: `INDEX_BITS];
    assign tag_q = req_q.addr[`ADDR_WIDTH-1 -: `TAG_BITS];

    // both arrays read at the incoming index in the request cycle
    assign tag_en = req_valid;
    assign tag_index = req_index;
    assign data_index = req_index;

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        req_q <= req;
    end

    // compare against the registered tag, one cycle after the read
    assign sel_way0 = valid_q & tag_dout.way0.valid & (tag_dout.way0.tag == tag_q);
    assign sel_way1 = valid_q & tag_dout.way1.valid & (tag_dout.way1.tag == tag_q);

    assign lookup.valid = valid_q;
    assign lookup.sel_way0 = sel_way0;
    assign lookup.sel_way1 = sel_way1;
    assign lookup.way_valid = {tag_dout.way1.valid, tag_dout.way0.valid};
    assign lookup.req = req_q;

endmodule

/* hdl/miss_execute.sv */
`timescale 1ns/100ps

`include "dcache_defines.svh"

module miss_execute
    import dcache_pkg::*;
(
    input logic clk,
    input logic init,
    input lookup_t lookup,
    input logic victim_way,
    input logic mem_req_ready,
    input logic mem_resp_valid,
    input block_t mem_resp_data,
    output logic mem_req_valid,
    output mem_req_t mem_req,
    output logic tag_we,
    output logic [1:0] tag_wmask,
    output tag_set_t tag_din,
    output logic data_en,
    output logic data_we,
    output logic [15:0] data_wmask,
    output data_set_t data_din,
    output index_t data_waddr,
    output logic refill_busy
);

    tag_t lk_tag;
    index_t lk_index;
    offset_t lk_offset;
    logic hit;
    logic store_hit;
    logic refill;
    logic victim;
    logic waiting;    // one request outstanding
    logic wait_read;  // the outstanding one is a refill
    logic [1:0] wr_cnt;
    logic [`BLOCK_BYTES-1:0] store_mask;
    block_t store_block;

    assign {lk_tag, lk_index, lk_offset} = lookup.req.addr;
    assign hit = lookup.sel_way0 | lookup.sel_way1;
    assign store_hit = lookup.valid & hit & (lookup.req.req_type == WRITE);
    assign refill = mem_resp_valid & wait_read; // write acks touch no array

    // empty way first, lfsr only when the set is full
    assign victim = (lookup.way_valid == 2'b11) ? victim_way : lookup.way_valid[0];

    always_comb begin
        case (lookup.req.width)
            BYTE: begin
                store_mask = `BLOCK_BYTES'(8'b0000_0001) << lk_offset;
                store_block = {(`BLOCK_WIDTH / 8){lookup.req.wr_data[7:0]}};
            end
            HALFWORD: begin
                store_mask = `BLOCK_BYTES'(8'b0000_0011) << lk_offset;
                store_block = {(`BLOCK_WIDTH / 16){lookup.req.wr_data[15:0]}};
            end
            default: begin
                store_mask = `BLOCK_BYTES'(8'b0000_1111) << lk_offset;
                store_block = {(`BLOCK_WIDTH / `WORD_WIDTH){lookup.req.wr_data}};
            end
        endcase
    end

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            waiting <= 1'b0;
            wait_read <= 1'b0;
            wr_cnt <= 2'd0;
        end else begin
            if (mem_req_valid & mem_req_ready) begin
                waiting <= 1'b1;
                wait_read <= (mem_req.req_type == READ);
            end else if (mem_resp_valid) begin
                waiting <= 1'b0;
                wait_read <= 1'b0;
            end
            if (refill) begin
                wr_cnt <= 2'd2; // tag read-back settles after two cycles
            end else if (wr_cnt != 2'd0) begin
                wr_cnt <= wr_cnt - 2'd1;
            end
        end
    end

    // miss asks for a block, store hit is written through
    assign mem_req_valid = lookup.valid & ~waiting & (wr_cnt == 2'd0) &
                           (~hit | (lookup.req.req_type == WRITE));
    assign mem_req.req_type = hit ? WRITE : READ;
    assign mem_req.block_addr = {lk_tag, lk_index};
    assign mem_req.block_data = store_block;
    assign mem_req.width = lookup.req.width;
    assign mem_req.addr = lookup.req.addr;

    assign tag_we = refill;
    assign tag_wmask = {victim, ~victim};
    assign tag_din = '{way1: '{valid: 1'b1, tag: lk_tag}, way0: '{valid: 1'b1, tag: lk_tag}};

    // lookup owns the data port at the registered index
    assign data_en = lookup.valid | refill;
    assign data_we = refill | store_hit;
    assign data_waddr = lk_index;
    assign data_wmask = refill ? {{`BLOCK_BYTES{victim}}, {`BLOCK_BYTES{~victim}}} :
                                 {store_mask & {`BLOCK_BYTES{lookup.sel_way1}},
                                  store_mask & {`BLOCK_BYTES{lookup.sel_way0}}};
    assign data_din = refill ? {mem_resp_data, mem_resp_data} : {store_block, store_block};

    assign refill_busy = (wr_cnt != 2'd0) | mem_req_valid;

endmodule

/* hdl/resp_result.sv */
`timescale 1ns/100ps

module resp_result
    import dcache_pkg::*;
(
    input logic clk,
    input logic init,
    input lookup_t lookup,
    input data_set_t data_dout,
    input logic refill_busy,
    output logic resp_valid,
    output word_t rd_data
);

    localparam int WORD_SEL_BIT = $clog2($bits(word_t) / 8);

    logic sel0_q;
    logic sel1_q;
    logic was_valid; // held request still in the pipe after a pulse
    logic word_sel;
    block_t blk;

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            sel0_q <= 1'b0;
            sel1_q <= 1'b0;
            was_valid <= 1'b0;
        end else begin
            // the two lookups after a pulse still carry the old request
            sel0_q <= lookup.sel_way0 & ~resp_valid & ~was_valid;
            sel1_q <= lookup.sel_way1 & ~resp_valid & ~was_valid;
            was_valid <= resp_valid;
        end
    end

    always_ff @(posedge clk) begin
        word_sel <= lookup.req.addr[WORD_SEL_BIT];
    end

    assign resp_valid = (sel0_q | sel1_q) & ~refill_busy;

    assign blk = sel1_q ? data_dout.way1 : data_dout.way0;
    assign rd_data = blk[word_sel*$bits(word_t) +: $bits(word_t)]; // aligned word

endmodule

/* hdl/dcache_top.sv */
`timescale 1ns/100ps

`include "dcache_defines.svh"

module dcache_top
    import dcache_pkg::*;
(
    input logic clk,
    input logic init,
    input logic req_valid,
    input cache_req_t req,
    output logic resp_valid,
    output word_t rd_data,
    output logic mem_req_valid,
    output mem_req_t mem_req,
    input logic mem_req_ready,
    input logic mem_resp_valid,
    input block_t mem_resp_data
);

    lookup_t lookup;
    logic victim_way;
    logic refill_busy;

    logic tag_en;
    index_t tag_index;
    index_t data_index;
    tag_set_t tag_dout;
    logic tag_we;
    logic [1:0] tag_wmask;
    tag_set_t tag_din;

    logic data_en;
    logic data_we;
    logic [15:0] data_wmask;
    data_set_t data_din;
    data_set_t data_dout;
    index_t data_waddr;

    logic tag_arr_en;
    index_t tag_arr_addr;
    logic data_arr_en;
    index_t data_arr_addr;

    // refill writes and the lookup share each single port
    assign tag_arr_en = tag_en | tag_we;
    assign tag_arr_addr = tag_we ? data_waddr : tag_index;
    assign data_arr_en = data_en | tag_en;
    assign data_arr_addr = data_en ? data_waddr : data_index;

    sram_1rw #(.payload_t(tag_set_t), .DEPTH(`N_SETS), .LANES(2)) tag_array (
        .clk(clk), .init(init), .en(tag_arr_en), .we(tag_we), .wmask(tag_wmask),
        .addr(tag_arr_addr), .din(tag_din), .dout(tag_dout)
    );

    sram_1rw #(.payload_t(data_set_t), .DEPTH(`N_SETS), .LANES(16)) data_array (
        .clk(clk), .init(init), .en(data_arr_en), .we(data_we), .wmask(data_wmask),
        .addr(data_arr_addr), .din(data_din), .dout(data_dout)
    );

    way_lfsr lfsr (.clk(clk), .init(init), .way(victim_way));

    tag_decode decode (
        .clk(clk), .init(init), .req_valid(req_valid), .req(req), .tag_dout(tag_dout),
        .tag_en(tag_en), .tag_index(tag_index), .data_index(data_index), .lookup(lookup)
    );

    miss_execute execute (
        .clk(clk), .init(init), .lookup(lookup), .victim_way(victim_way),
        .mem_req_ready(mem_req_ready), .mem_resp_valid(mem_resp_valid),
        .mem_resp_data(mem_resp_data), .mem_req_valid(mem_req_valid), .mem_req(mem_req),
        .tag_we(tag_we), .tag_wmask(tag_wmask), .tag_din(tag_din),
        .data_en(data_en), .data_we(data_we), .data_wmask(data_wmask),
        .data_din(data_din), .data_waddr(data_waddr), .refill_busy(refill_busy)
    );

    resp_result result (
        .clk(clk), .init(init), .lookup(lookup), .data_dout(data_dout),
        .refill_busy(refill_busy), .resp_valid(resp_valid), .rd_data(rd_data)
    );

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic init
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        init = 1'b1;
        repeat (3) @(posedge clk);
        init <= 1'b0;
    end

endmodule

/* sim/tb_dcache.sv */
`timescale 1ns/100ps

`include "dcache_defines.svh"

module tb_dcache
    import dcache_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic clk;
    logic init;
    logic req_valid;
    cache_req_t req;
    logic resp_valid;
    word_t rd_data;
    logic mem_req_valid;
    mem_req_t mem_req;
    logic mem_req_ready;
    logic mem_resp_valid;
    block_t mem_resp_data;

    block_t mem_model [256]; // what the memory controller holds
    block_t shadow [256];    // expected contents from the issued stores
    cache_req_t cur_req;
    word_t exp_word;
    logic mem_busy;
    int n_rd;
    int n_wr;
    int first_type; // -1 none yet
    int errors;
    int timeouts;
    int requests;
    int last_cycles;
    logic saw_mem_valid;
    logic [31:0] stim_rng;
    logic [31:0] mem_rng;

    tb_clock_gen clock_gen (.clk(clk), .init(init));

    dcache_top uut (
        .clk(clk), .init(init), .req_valid(req_valid), .req(req),
        .resp_valid(resp_valid), .rd_data(rd_data),
        .mem_req_valid(mem_req_valid), .mem_req(mem_req),
        .mem_req_ready(mem_req_ready), .mem_resp_valid(mem_resp_valid),
        .mem_resp_data(mem_resp_data)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int width_bytes(input req_width_t w);
        case (w)
            BYTE: return 1;
            HALFWORD: return 2;
            default: return 4;
        endcase
    endfunction

    // request must target the current block, a WRITE must carry the store
    function automatic logic mem_req_ok(input mem_req_t m, input cache_req_t r);
        int off;
        logic ok;
        off = r.addr[2:0];
        ok = (m.block_addr == r.addr[31:3]);
        if (m.req_type == WRITE) begin
            ok = ok & (r.req_type == WRITE) & (m.addr == r.addr) & (m.width == r.width);
            for (int i = 0; i < width_bytes(r.width); i++) begin
                ok = ok & (m.block_data[(off+i)*8 +: 8] == r.wr_data[i*8 +: 8]);
            end
        end
        return ok;
    endfunction

    a_reset_quiet: assert property (@(posedge clk) (init || $fell(init)) |->
                                    (!resp_valid && !mem_req_valid))
        else begin
            errors++;
            $display("[ERROR] %0t resp_valid/mem_req_valid got %b%b expected 00", $time,
                     $sampled(resp_valid), $sampled(mem_req_valid));
        end

    a_req_stable: assert property (@(posedge clk) disable iff (init)
                                   (mem_req_valid && !mem_req_ready) |=>
                                   (mem_req_valid && $stable(mem_req)))
        else begin
            errors++;
            $display("mem_req_valid or mem_req changed before the request was accepted");
        end

    a_mem_req: assert property (@(posedge clk) disable iff (init)
                                (mem_req_valid && mem_req_ready) |->
                                mem_req_ok(mem_req, cur_req))
        else begin
            errors++;
            $display("[ERROR] %0t mem_req got %h expected for request %h", $time,
                     $sampled(mem_req), $sampled(cur_req));
        end

    a_rd_data: assert property (@(posedge clk) disable iff (init)
                                (resp_valid && cur_req.req_type == READ) |->
                                (rd_data == exp_word))
        else begin
            errors++;
            $display("[ERROR] %0t rd_data got %h expected %h", $time,
                     $sampled(rd_data), $sampled(exp_word));
        end

    // memory controller model
    initial begin : memory_model
        mem_req_t m;
        int lat;
        mem_req_ready = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data = '0;
        mem_busy = 1'b0;
        mem_rng = 32'h2d80_49dd;
        for (int i = 0; i < 256; i++) begin
            mem_rng = xorshift(mem_rng);
            mem_model[i][63:32] = mem_rng;
            mem_rng = xorshift(mem_rng);
            mem_model[i][31:0] = mem_rng;
            shadow[i] = mem_model[i];
        end
        forever begin
            @(negedge clk);
            if (mem_req_valid && !init) begin
                mem_busy = 1'b1;
                mem_rng = xorshift(mem_rng);
                repeat (mem_rng % 4) @(negedge clk); // back-pressure
                @(posedge clk);
                mem_req_ready <= 1'b1;
                @(negedge clk);
                m = mem_req;
                if (m.req_type == READ) n_rd++;
                else n_wr++;
                if (first_type < 0) first_type = int'(m.req_type);
                @(posedge clk);
                mem_req_ready <= 1'b0;
                if (m.req_type == WRITE) begin
                    for (int i = 0; i < width_bytes(m.width); i++) begin
                        mem_model[m.block_addr[7:0]][(m.addr[2:0]+i)*8 +: 8] =
                            m.block_data[(m.addr[2:0]+i)*8 +: 8];
                    end
                end
                mem_rng = xorshift(mem_rng);
                lat = 2 + (mem_rng % 4);
                repeat (lat - 1) @(posedge clk);
                mem_resp_valid <= 1'b1;
                mem_resp_data <= (m.req_type == READ) ? mem_model[m.block_addr[7:0]] : '0;
                @(posedge clk);
                mem_resp_valid <= 1'b0;
                mem_busy = 1'b0;
            end
        end
    end

    task automatic report_and_finish();
        $display("requests: %0d, errors: %0d, timeouts: %0d", requests, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic expect_equal(input string what, input int got, input int exp);
        assert (got == exp)
        else begin
            errors++;
            $display("[ERROR] %0t %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // one request, held until resp_valid
    task automatic issue(input req_type_t t, input req_width_t w, input addr_t a,
                         input word_t d);
        int n;
        n = 0;
        while (mem_busy) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                timeouts++;
                $display("timed out waiting for the memory model to go idle");
                report_and_finish();
            end
        end
        cur_req = '{req_type: t, width: w, addr: a, wr_data: d};
        if (t == WRITE) begin
            for (int i = 0; i < width_bytes(w); i++) begin
                shadow[a[10:3]][(a[2:0]+i)*8 +: 8] = d[i*8 +: 8];
            end
        end
        exp_word = shadow[a[10:3]][a[2]*32 +: 32];
        n_rd = 0;
        n_wr = 0;
        first_type = -1;
        saw_mem_valid = 1'b0;
        requests++;
        @(posedge clk);
        req_valid <= 1'b1;
        req <= cur_req;
        last_cycles = 0;
        forever begin
            @(negedge clk);
            if (resp_valid) break;
            if (mem_req_valid) saw_mem_valid = 1'b1;
            last_cycles++;
            if (last_cycles > TIMEOUT) begin
                timeouts++;
                $display("timed out waiting for resp_valid at address %h", a);
                report_and_finish();
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;
        @(posedge clk); // one idle cycle between requests
    endtask

    initial begin : stimulus
        int n;
        addr_t a;
        int off;
        req_width_t w;
        req_valid = 1'b0;
        req = '0;
        errors = 0;
        timeouts = 0;
        requests = 0;
        stim_rng = xorshift(32'h2d80_49dd);
        n = 0;
        while (init !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                timeouts++;
                $display("timed out waiting for init to drop");
                report_and_finish();
            end
        end
        repeat (2) @(posedge clk);

        // read miss, then hits on both words of the block
        issue(READ, WORD, 32'h040, '0);
        expect_equal("read miss READ count", n_rd, 1);
        expect_equal("read miss WRITE count", n_wr, 0);
        issue(READ, WORD, 32'h044, '0);
        expect_equal("read hit latency", last_cycles, 2);
        expect_equal("read hit memory requests", int'(saw_mem_valid), 0);
        issue(READ, WORD, 32'h040, '0);
        expect_equal("read hit latency", last_cycles, 2);

        // store hits of all widths
        for (int i = 0; i < 12; i++) begin
            stim_rng = xorshift(stim_rng);
            w = req_width_t'(stim_rng % 3);
            case (w)
                BYTE: off = (stim_rng >> 4) % 8;
                HALFWORD: off = ((stim_rng >> 4) % 4) * 2;
                default: off = ((stim_rng >> 4) % 2) * 4;
            endcase
            stim_rng = xorshift(stim_rng);
            issue(WRITE, w, 32'h040 | off, stim_rng);
            expect_equal("store hit WRITE count", n_wr, 1);
            expect_equal("store hit READ count", n_rd, 0);
            issue(READ, WORD, 32'h040 | (off & 4), '0);
        end

        // store miss refills first, then writes through
        stim_rng = xorshift(stim_rng);
        issue(WRITE, HALFWORD, 32'h44a, stim_rng);
        expect_equal("store miss READ count", n_rd, 1);
        expect_equal("store miss WRITE count", n_wr, 1);
        expect_equal("store miss first request type", first_type, int'(READ));
        issue(READ, WORD, 32'h448, '0);
        issue(READ, WORD, 32'h44c, '0);

        // three tags on index 0x15 compete for two ways
        for (int i = 0; i < 30; i++) begin
            stim_rng = xorshift(stim_rng);
            a = ((1 + (stim_rng % 3)) << 9) | (32'h15 << 3) | (((stim_rng >> 8) % 2) * 4);
            issue(READ, WORD, a, '0);
        end

        repeat (10) @(posedge clk);
        report_and_finish();
    end

endmodule

/* list.f */
+incdir+include
hdl/dcache_pkg.sv
hdl/sram_1rw.sv
hdl/way_lfsr.sv
hdl/tag_decode.sv
hdl/miss_execute.sv
hdl/resp_result.sv
hdl/dcache_top.sv
sim/tb_clock_gen.sv
sim/tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - include

sources:
  - hdl/dcache_pkg.sv
  - hdl/sram_1rw.sv
  - hdl/way_lfsr.sv
  - hdl/tag_decode.sv
  - hdl/miss_execute.sv
  - hdl/resp_result.sv
  - hdl/dcache_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_dcache.sv
